/* design/mrr_bit_demod.sv */
`timescale 1ns/100ps
`include "mrr_defines.svh"

module mrr_bit_demod (
    input  logic                   clk,
    input  logic                   rst,
    input  mrr_pkg::esamp_t        i_sample,
    input  logic                   i_sample_valid,
    input  logic                   i_rx_active,
    input  mrr_pkg::mrr_cycle_t    i_cycle,
    input  logic                   i_cycle_tick,
    output mrr_pkg::cycle_energy_t o_cycle_energy,
    output logic                   o_chip_valid,
    output logic                   o_chip
);
    import mrr_pkg::*;

    // a slot sum is only complete on the tick after its second cycle
    localparam mrr_cycle_t ZERO_LATCH = mrr_cycle_t'(`MRR_ZERO_SLOT_FIRST + 1);
    localparam mrr_cycle_t ZERO_ADD   = mrr_cycle_t'(`MRR_ZERO_SLOT_FIRST + 2);
    localparam mrr_cycle_t ONE_LATCH  = mrr_cycle_t'(`MRR_ONE_SLOT_FIRST + 1);
    localparam mrr_cycle_t CHIP_CYCLE = mrr_cycle_t'(`MRR_ONE_SLOT_FIRST + 2);

    logic [$bits(cycle_energy_t):0] zero_sum;
    logic [$bits(cycle_energy_t):0] one_sum;
    logic [$bits(cycle_energy_t):0] one_total;

    // energy of the running cycle, holds the full sum on the tick clock
    always_ff @(posedge clk) begin
        if (rst || !i_rx_active) begin
            o_cycle_energy <= '0;
        end else if (i_cycle_tick) begin
            o_cycle_energy <= i_sample_valid ? cycle_energy_t'(i_sample) : '0;
        end else if (i_sample_valid) begin
            o_cycle_energy <= o_cycle_energy + cycle_energy_t'(i_sample);
        end
    end

    // zero slot is cycles 2-3, one slot is cycles 4-5
    always_ff @(posedge clk) begin
        if (i_cycle_tick) begin
            if (i_cycle == ZERO_LATCH) begin
                zero_sum <= {1'b0, o_cycle_energy};
            end else if (i_cycle == ZERO_ADD) begin
                zero_sum <= zero_sum + {1'b0, o_cycle_energy};
            end
            if (i_cycle == ONE_LATCH) begin
                one_sum <= {1'b0, o_cycle_energy};
            end
        end
    end

    // last one-slot cycle is added on the fly at the decision tick
    assign one_total = one_sum + {1'b0, o_cycle_energy};

    assign o_chip_valid = i_rx_active && i_cycle_tick && (i_cycle == CHIP_CYCLE);
    assign o_chip       = zero_sum > one_total;

endmodule

/* design/mrr_cycle_timer.sv */
`timescale 1ns/100ps
`include "mrr_defines.svh"

module mrr_cycle_timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_clear,
    input  logic                i_restart,
    input  logic                i_step,
    output mrr_pkg::mrr_cycle_t o_cycle,
    output logic                o_cycle_tick
);

    logic [`MRR_OSR_LOG2-1:0] sub_cnt;
    logic                     cycle_done;

    // last sample strobe of the current MRR cycle
    assign cycle_done = i_step && (sub_cnt == `MRR_OSR_LOG2'(`MRR_OSR - 1));

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            sub_cnt      <= '0;
            o_cycle      <= '0;
            o_cycle_tick <= 1'b0;
        end else begin
            o_cycle_tick <= cycle_done;
            if (i_step) begin
                sub_cnt <= sub_cnt + 1'b1;
            end
            // restart wraps the index to 0 instead of counting on
            if (cycle_done) begin
                o_cycle <= i_restart ? '0 : o_cycle + 1'b1;
            end
        end
    end

    // clear comes from the ready state and restart only from the active states
    a_clear_restart_excl: assert property (
        @(posedge clk) disable iff (rst) !(i_clear && i_restart)
    ) else $error("timer clear and restart asserted together");

endmodule

/* design/mrr_defines.svh */
`ifndef MRR_DEFINES_SVH
`define MRR_DEFINES_SVH

// oversampling of the MRR clock by the energy sample strobe
`define MRR_OSR_LOG2 2
`define MRR_OSR (1 << `MRR_OSR_LOG2)
`define MRR_ESAMP_WIDTH 16

// PN code sent MSB first, searched over a window of candidate offsets
`define MRR_PN_SEQ_LEN 15
`define MRR_PN_SEQ 15'b000100110101111
`define MRR_SYNC_SEARCH_LEN 8
`define MRR_SYNC_SEARCH_LEN_LOG2 3
`define MRR_CHIP_ADDR_WIDTH 5

// loopback transmit and metadata trailer
`define MRR_TX_WORD_BITS 32
`define MRR_TX_CYCLES_PER_BIT 4
`define MRR_NUM_METADATA 7

// first MRR cycle of each two-cycle chip slot inside a bit
`define MRR_ZERO_SLOT_FIRST 2
`define MRR_ONE_SLOT_FIRST 4

`endif

/* design/mrr_loopback.sv */
`timescale 1ns/100ps

module mrr_loopback (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_fm_flag,
    input  mrr_pkg::esamp_t     i_sample,
    input  logic                i_sample_valid,
    input  logic                i_tx_disable,
    input  mrr_pkg::mrr_cycle_t i_wait_step,
    input  mrr_pkg::word_t      i_tx_word,
    input  logic [7:0]          i_num_payload_bits,
    input  logic [7:0]          i_recharge_len,
    input  logic [15:0]         i_fft_len,
    input  mrr_pkg::word_t      i_cfo_idx,
    input  mrr_pkg::word_t      i_sfo_idx,
    input  logic [63:0]         i_cur_time,
    input  mrr_pkg::word_t      i_cur_corr,
    input  logic [63:0]         i_cur_metadata,
    output mrr_pkg::word_t      o_decoded_tdata,
    output logic                o_decoded_tvalid,
    output logic                o_decoded_tlast,
    output logic                o_tkeep,
    output logic                o_tx_en,
    output logic                o_detector_reset,
    output logic                o_currently_decoding
);
    import mrr_pkg::*;

    logic          timer_clear;
    logic          timer_restart;
    logic          timer_step;
    logic          rx_active;
    logic          chip_restart;
    mrr_cycle_t    cycle;
    logic          cycle_tick;
    cycle_energy_t cycle_energy;
    logic          chip_valid;
    logic          chip;
    logic          sync_done;
    sync_offset_t  sync_offset;

    mrr_cycle_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (timer_clear),
        .i_restart    (timer_restart),
        .i_step       (timer_step),
        .o_cycle      (cycle),
        .o_cycle_tick (cycle_tick)
    );

    mrr_bit_demod u_demod (
        .clk            (clk),
        .rst            (rst),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .i_rx_active    (rx_active),
        .i_cycle        (cycle),
        .i_cycle_tick   (cycle_tick),
        .o_cycle_energy (cycle_energy),
        .o_chip_valid   (chip_valid),
        .o_chip         (chip)
    );

    pn_sync_search u_sync (
        .clk           (clk),
        .rst           (rst),
        .i_restart     (chip_restart),
        .i_chip_valid  (chip_valid),
        .i_chip        (chip),
        .o_sync_done   (sync_done),
        .o_sync_offset (sync_offset)
    );

    mrr_loopback_ctrl u_ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .i_fm_flag            (i_fm_flag),
        .i_sample_valid       (i_sample_valid),
        .i_tx_disable         (i_tx_disable),
        .i_wait_step          (i_wait_step),
        .i_tx_word            (i_tx_word),
        .i_num_payload_bits   (i_num_payload_bits),
        .i_recharge_len       (i_recharge_len),
        .i_fft_len            (i_fft_len),
        .i_cycle              (cycle),
        .i_cycle_tick         (cycle_tick),
        .i_cycle_energy       (cycle_energy),
        .i_sync_done          (sync_done),
        .i_sync_offset        (sync_offset),
        .i_cfo_idx            (i_cfo_idx),
        .i_sfo_idx            (i_sfo_idx),
        .i_cur_time           (i_cur_time),
        .i_cur_corr           (i_cur_corr),
        .i_cur_metadata       (i_cur_metadata),
        .o_timer_clear        (timer_clear),
        .o_timer_restart      (timer_restart),
        .o_timer_step         (timer_step),
        .o_rx_active          (rx_active),
        .o_chip_restart       (chip_restart),
        .o_decoded_tdata      (o_decoded_tdata),
        .o_decoded_tvalid     (o_decoded_tvalid),
        .o_decoded_tlast      (o_decoded_tlast),
        .o_tkeep              (o_tkeep),
        .o_tx_en              (o_tx_en),
        .o_detector_reset     (o_detector_reset),
        .o_currently_decoding (o_currently_decoding)
    );

endmodule

/* design/mrr_loopback_ctrl.sv */
`timescale 1ns/100ps
`include "mrr_defines.svh"

module mrr_loopback_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_fm_flag,
    input  logic                   i_sample_valid,
    input  logic                   i_tx_disable,
    input  mrr_pkg::mrr_cycle_t    i_wait_step,
    input  mrr_pkg::word_t         i_tx_word,
    input  logic [7:0]             i_num_payload_bits,
    input  logic [7:0]             i_recharge_len,
    input  logic [15:0]            i_fft_len,
    input  mrr_pkg::mrr_cycle_t    i_cycle,
    input  logic                   i_cycle_tick,
    input  mrr_pkg::cycle_energy_t i_cycle_energy,
    input  logic                   i_sync_done,
    input  mrr_pkg::sync_offset_t  i_sync_offset,
    input  mrr_pkg::word_t         i_cfo_idx,
    input  mrr_pkg::word_t         i_sfo_idx,
    input  logic [63:0]            i_cur_time,
    input  mrr_pkg::word_t         i_cur_corr,
    input  logic [63:0]            i_cur_metadata,
    output logic                   o_timer_clear,
    output logic                   o_timer_restart,
    output logic                   o_timer_step,
    output logic                   o_rx_active,
    output logic                   o_chip_restart,
    output mrr_pkg::word_t         o_decoded_tdata,
    output logic                   o_decoded_tvalid,
    output logic                   o_decoded_tlast,
    output logic                   o_tkeep,
    output logic                   o_tx_en,
    output logic                   o_detector_reset,
    output logic                   o_currently_decoding
);
    import mrr_pkg::*;

    localparam int TX_BIT_W = $clog2(`MRR_TX_WORD_BITS);
    localparam mrr_cycle_t TX_LAST_CYCLE = mrr_cycle_t'(`MRR_TX_CYCLES_PER_BIT - 1);
    localparam mrr_cycle_t TX_HALF = mrr_cycle_t'(`MRR_TX_CYCLES_PER_BIT / 2);

    loopback_state_t     state;
    loopback_state_t     next_state;
    logic [8:0]          payload_cnt;
    logic [TX_BIT_W-1:0] tx_bit;
    logic [17:0]         guard_cnt;
    logic [2:0]          meta_idx;
    logic                sync_seen;
    logic                boundary;
    logic                rx_done;
    logic                meta_last;
    mrr_cycle_t          bit_last_cycle;
    word_t               meta_word;

    // the timer wraps to cycle 0 at every bit boundary
    assign boundary       = i_cycle_tick && (i_cycle == '0);
    assign bit_last_cycle = mrr_cycle_t'(i_recharge_len) + mrr_cycle_t'(2);
    assign meta_last      = (meta_idx == 3'(`MRR_NUM_METADATA - 1));
    assign rx_done = sync_seen &&
        ((payload_cnt + 9'd1 - 9'(i_sync_offset)) == {1'b0, i_num_payload_bits});

    always_comb begin
        next_state = state;
        case (state)
            st_ready:             if (i_fm_flag) next_state = st_rx_payload;
            st_rx_payload:        if (boundary && rx_done) next_state = st_wait_turnaround;
            st_wait_turnaround:   if (boundary) next_state = st_tx;
            st_tx: begin
                if (boundary && tx_bit == TX_BIT_W'(`MRR_TX_WORD_BITS - 1)) begin
                    next_state = st_self_trigger_wait;
                end
            end
            st_self_trigger_wait: if (guard_cnt == {i_fft_len, 2'b00}) next_state = st_send_metadata;
            st_send_metadata:     if (meta_last) next_state = st_ready;
            default:              next_state = st_ready;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_ready;
            payload_cnt <= '0;
            tx_bit      <= '0;
            guard_cnt   <= '0;
            meta_idx    <= '0;
            sync_seen   <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_ready) begin
                payload_cnt <= '0;
                tx_bit      <= '0;
                guard_cnt   <= '0;
                meta_idx    <= '0;
                sync_seen   <= 1'b0;
            end else begin
                if (i_sync_done) begin
                    sync_seen <= 1'b1;
                end
                if (state == st_rx_payload && boundary) begin
                    payload_cnt <= payload_cnt + 1'b1;
                end
                if (state == st_tx && boundary) begin
                    tx_bit <= tx_bit + 1'b1;
                end
                if (state == st_self_trigger_wait && i_sample_valid) begin
                    guard_cnt <= guard_cnt + 1'b1;
                end
                if (state == st_send_metadata) begin
                    meta_idx <= meta_idx + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (meta_idx)
            3'd0:    meta_word = i_cfo_idx;
            3'd1:    meta_word = i_sfo_idx;
            3'd2:    meta_word = i_cur_time[63:32];
            3'd3:    meta_word = i_cur_time[31:0];
            3'd4:    meta_word = i_cur_corr;
            3'd5:    meta_word = i_cur_metadata[63:32];
            default: meta_word = i_cur_metadata[31:0];
        endcase
    end

    always_comb begin
        o_timer_clear    = (state == st_ready);
        o_chip_restart   = (state == st_ready);
        o_rx_active      = (state == st_rx_payload);
        o_timer_step     = 1'b0;
        o_timer_restart  = 1'b0;
        o_decoded_tdata  = word_t'(i_cycle_energy);
        o_decoded_tvalid = 1'b0;
        o_decoded_tlast  = 1'b0;
        o_tkeep          = 1'b0;
        o_tx_en          = 1'b0;
        o_detector_reset = 1'b0;
        case (state)
            st_rx_payload: begin
                o_timer_step     = i_sample_valid;
                o_timer_restart  = (i_cycle == bit_last_cycle);
                // one soft word per finished cycle, the word at cycle 0 is dropped
                o_decoded_tvalid = i_cycle_tick && (i_cycle != '0);
                o_decoded_tlast  = i_cycle_tick && (i_cycle == bit_last_cycle);
            end
            st_wait_turnaround: begin
                o_timer_step    = i_sample_valid;
                o_timer_restart = (i_cycle == i_wait_step - 1'b1);
                o_tx_en         = !i_tx_disable;
            end
            st_tx: begin
                o_timer_step    = i_sample_valid;
                o_timer_restart = (i_cycle == TX_LAST_CYCLE);
                o_tx_en         = !i_tx_disable;
                // a one keys the first half of the bit, a zero the second half
                o_tkeep = !i_tx_disable &&
                    (i_tx_word[tx_bit] ? (i_cycle < TX_HALF) : (i_cycle >= TX_HALF));
            end
            st_self_trigger_wait: begin
                o_detector_reset = 1'b1;
            end
            st_send_metadata: begin
                o_decoded_tdata  = meta_word;
                o_decoded_tvalid = 1'b1;
                o_decoded_tlast  = meta_last;
            end
            default: begin
            end
        endcase
    end

    assign o_currently_decoding = (state != st_ready);

endmodule

/* design/mrr_pkg.sv */
`include "mrr_defines.svh"

package mrr_pkg;

    typedef logic [`MRR_ESAMP_WIDTH-1:0] esamp_t;
    // sum of MRR_OSR samples needs MRR_OSR_LOG2 extra bits
    typedef logic [`MRR_ESAMP_WIDTH+`MRR_OSR_LOG2-1:0] cycle_energy_t;
    typedef logic [15:0] mrr_cycle_t;
    typedef logic [`MRR_CHIP_ADDR_WIDTH-1:0] chip_addr_t;
    typedef logic [`MRR_SYNC_SEARCH_LEN_LOG2-1:0] sync_offset_t;
    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        st_ready,
        st_rx_payload,
        st_wait_turnaround,
        st_tx,
        st_self_trigger_wait,
        st_send_metadata
    } loopback_state_t;

    typedef enum logic [2:0] {
        ps_idle,
        ps_corr,
        ps_corr_drain,
        ps_next_offset,
        ps_set_result
    } pn_search_state_t;

endpackage

/* design/pn_sync_search.sv */
`timescale 1ns/100ps
`include "mrr_defines.svh"

module pn_sync_search (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_restart,
    input  logic                  i_chip_valid,
    input  logic                  i_chip,
    output logic                  o_sync_done,
    output mrr_pkg::sync_offset_t o_sync_offset
);
    import mrr_pkg::*;

    localparam logic [`MRR_PN_SEQ_LEN-1:0] PN_CODE = `MRR_PN_SEQ;
    localparam chip_addr_t LAST_SYNC_CHIP =
        chip_addr_t'(`MRR_PN_SEQ_LEN + `MRR_SYNC_SEARCH_LEN - 1);
    localparam logic [3:0] LAST_PN_IDX = 4'(`MRR_PN_SEQ_LEN - 1);

    pn_search_state_t  state;
    pn_search_state_t  next_state;
    logic              chip_mem [0:(1 << `MRR_CHIP_ADDR_WIDTH)-1];
    chip_addr_t        wr_addr;
    chip_addr_t        rd_addr;
    logic              rd_chip;
    logic              armed;
    logic              start;
    sync_offset_t      offset;
    sync_offset_t      best_offset;
    logic [3:0]        chip_idx;
    logic              pn_bit_q;
    logic              score_en;
    logic signed [4:0] score;
    logic signed [4:0] best_score;

    // search runs once per packet, on the chip that completes sync plus PN
    assign start   = armed && i_chip_valid && (wr_addr == LAST_SYNC_CHIP);
    assign rd_addr = chip_addr_t'(offset) + chip_addr_t'(chip_idx);

    always_ff @(posedge clk) begin
        if (i_chip_valid) begin
            chip_mem[wr_addr] <= i_chip;
        end
        rd_chip <= chip_mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
            armed   <= 1'b0;
        end else if (i_restart) begin
            wr_addr <= '0;
            armed   <= 1'b1;
        end else if (i_chip_valid) begin
            wr_addr <= wr_addr + 1'b1;
            if (start) begin
                armed <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ps_idle:        if (start) next_state = ps_corr;
            ps_corr:        if (chip_idx == LAST_PN_IDX) next_state = ps_corr_drain;
            ps_corr_drain:  next_state = ps_next_offset;
            ps_next_offset: next_state = (offset == '1) ? ps_set_result : ps_corr;
            ps_set_result:  next_state = ps_idle;
            default:        next_state = ps_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ps_idle;
            score_en      <= 1'b0;
            offset        <= '0;
            chip_idx      <= '0;
            o_sync_done   <= 1'b0;
            o_sync_offset <= '0;
        end else begin
            state       <= next_state;
            // memory read lands one clock later, so the PN bit is delayed too
            score_en    <= (state == ps_corr);
            o_sync_done <= (state == ps_set_result);
            if (start) begin
                offset     <= '0;
                chip_idx   <= '0;
                score      <= '0;
                best_score <= '0;
            end else begin
                if (state == ps_corr) begin
                    chip_idx <= chip_idx + 1'b1;
                end
                if (score_en) begin
                    score <= (rd_chip == pn_bit_q) ? score + 5'sd1 : score - 5'sd1;
                end
                // strictly greater keeps the earliest offset on a tie
                if (state == ps_next_offset) begin
                    if (score > best_score) begin
                        best_score  <= score;
                        best_offset <= offset;
                    end
                    score    <= '0;
                    chip_idx <= '0;
                    offset   <= offset + 1'b1;
                end
            end
            if (i_restart) begin
                o_sync_offset <= '0;
            end else if (state == ps_set_result) begin
                o_sync_offset <= (best_score > 5'sd0) ? best_offset : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        pn_bit_q <= PN_CODE[LAST_PN_IDX - chip_idx];
    end

    // the whole search has to fit between two chip decisions
    a_no_chip_during_search: assert property (
        @(posedge clk) disable iff (rst) i_chip_valid |-> (state == ps_idle)
    ) else $error("chip arrived while the PN search was running");

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_mrr_loopback --Mdir obj_dir -o sim_mrr_loopback \
    && ./obj_dir/sim_mrr_loopback \
    || { echo "build or simulation failed"; exit 1; }

/* sources.f */
+incdir+design
+incdir+tb
design/mrr_pkg.sv
design/mrr_cycle_timer.sv
design/mrr_bit_demod.sv
design/pn_sync_search.sv
design/mrr_loopback_ctrl.sv
design/mrr_loopback.sv
tb/tb_mrr_loopback.sv

/* tb/mrr_loopback_tests.svh */
`ifndef MRR_LOOPBACK_TESTS_SVH
`define MRR_LOOPBACK_TESTS_SVH

localparam logic [14:0] PN       = `MRR_PN_SEQ;
localparam word_t       TX_WORD  = 32'ha5c3_0f96;
localparam word_t       CFO_VAL  = 32'h0000_0c1f;
localparam word_t       SFO_VAL  = 32'hffff_fe07;
localparam logic [63:0] TIME_VAL = 64'h0123_4567_89ab_cdef;
localparam word_t       CORR_VAL = 32'h0004_2a11;
localparam logic [63:0] META_VAL = 64'hfeed_0bad_5eed_1234;
localparam int          PULSE    = 1000;
localparam int          FLOOR    = 20;

logic  cap_tkeep;
logic  cap_tx_en;
logic  cap_det;
logic  cap_dec;
logic  cap_last;
word_t exp_words [$];
logic  exp_last [$];

function automatic int noisy(input int amp);
    noisy = amp + ($random(seed) & 15);
endfunction

// one sample strobe, outputs captured at the edge that takes the sample
task automatic drive_strobe(input int value);
    repeat (STROBE_CLKS - 1) @(posedge clk);
    i_sample       <= esamp_t'(value);
    i_sample_valid <= 1'b1;
    @(posedge clk);
    cap_tkeep = o_tkeep;
    cap_tx_en = o_tx_en;
    cap_det   = o_detector_reset;
    cap_dec   = o_currently_decoding;
    cap_last  = o_decoded_tlast;
    i_sample_valid <= 1'b0;
endtask

task automatic test_reset();
    for (int i = 0; i < 16; i++) begin
        drive_strobe(noisy(PULSE));
        check_bit(cap_tkeep, 1'b0, "tkeep while idle");
        check_bit(cap_tx_en, 1'b0, "tx_en while idle");
        check_bit(cap_det, 1'b0, "detector reset while idle");
        check_bit(cap_dec, 1'b0, "decoding while idle");
        check_bit(cap_last, 1'b0, "tlast while idle");
    end
    check_word(word_t'(got_words.size()), '0, "words without fm flag");
endtask

task automatic run_packet(input int k, input logic dis);
    logic  chips [0:MAX_BITS-1];
    int    bits;
    int    amp;
    int    sum;
    int    v;
    int    bit_idx;
    int    cyc;
    int    base;
    int    tlasts;
    int    waited;
    logic  exp_keep;
    logic  hot;
    word_t meta [0:6];
    bits = k + N_PAYLOAD;
    got_words.delete();
    got_last.delete();
    got_stamp.delete();
    exp_words.delete();
    exp_last.delete();
    // filler before the code, PN MSB first at offset k, random payload after
    for (int b = 0; b < bits; b++) begin
        if (b < k) begin
            chips[b] = (b % 3 == 0);
        end else if (b < k + 15) begin
            chips[b] = PN[14 - (b - k)];
        end else begin
            chips[b] = 1'($random(seed));
        end
    end
    @(posedge clk);
    i_tx_disable <= dis;
    i_fm_flag    <= 1'b1;
    @(posedge clk);
    i_fm_flag <= 1'b0;
    check_bit(o_currently_decoding, 1'b0, "decoding before fm flag");
    @(posedge clk);
    check_bit(o_currently_decoding, 1'b1, "decoding after fm flag");
    // a one chip puts the pulse in cycles 2-3, a zero chip in cycles 4-5
    for (int b = 0; b < bits; b++) begin
        for (int c = 0; c < RECHARGE + 3; c++) begin
            if (chips[b]) begin
                hot = (c >= `MRR_ZERO_SLOT_FIRST) && (c < `MRR_ZERO_SLOT_FIRST + 2);
            end else begin
                hot = (c >= `MRR_ONE_SLOT_FIRST) && (c < `MRR_ONE_SLOT_FIRST + 2);
            end
            amp = hot ? PULSE : FLOOR;
            sum = 0;
            for (int s = 0; s < `MRR_OSR; s++) begin
                v = noisy(amp);
                sum += v;
                drive_strobe(v);
                check_bit(cap_tkeep, 1'b0, "tkeep during receive");
                check_bit(cap_tx_en, 1'b0, "tx_en during receive");
            end
            if (c <= RECHARGE + 1) begin
                exp_words.push_back(word_t'(sum));
                exp_last.push_back(c == RECHARGE + 1);
            end
        end
    end
    for (int s = 0; s < WAIT_STEP * `MRR_OSR; s++) begin
        drive_strobe(noisy(FLOOR));
        check_bit(cap_tkeep, 1'b0, "tkeep during turnaround");
        check_bit(cap_tx_en, !dis, "tx_en during turnaround");
    end
    for (int s = 0; s < `MRR_TX_WORD_BITS * `MRR_TX_CYCLES_PER_BIT * `MRR_OSR; s++) begin
        drive_strobe(noisy(FLOOR));
        bit_idx  = s / (`MRR_TX_CYCLES_PER_BIT * `MRR_OSR);
        cyc      = (s / `MRR_OSR) % `MRR_TX_CYCLES_PER_BIT;
        exp_keep = !dis && (TX_WORD[bit_idx] ? (cyc < 2) : (cyc >= 2));
        check_bit(cap_tkeep, exp_keep, "tkeep during tx");
        check_bit(cap_tx_en, !dis, "tx_en during tx");
    end
    for (int s = 0; s < 4 * FFT_LEN; s++) begin
        drive_strobe(noisy(FLOOR));
        check_bit(cap_det, 1'b1, "detector reset during guard");
    end
    waited = 0;
    while (got_words.size() < exp_words.size() + 7 && waited < 40) begin
        @(posedge clk);
        waited++;
    end
    if (got_words.size() < exp_words.size() + 7) begin
        $display("Simulation FAILED");
        $fatal(1, "the metadata words never arrived on the decoded stream");
    end
    base   = exp_words.size();
    tlasts = 0;
    for (int i = 0; i < base; i++) begin
        check_word(got_words[i], exp_words[i], "soft symbol word");
        check_bit(got_last[i], exp_last[i], "soft symbol tlast");
        if (got_last[i]) begin
            tlasts++;
        end
    end
    check_word(word_t'(tlasts), word_t'(bits), "decoded bit count");
    meta[0] = CFO_VAL;
    meta[1] = SFO_VAL;
    meta[2] = TIME_VAL[63:32];
    meta[3] = TIME_VAL[31:0];
    meta[4] = CORR_VAL;
    meta[5] = META_VAL[63:32];
    meta[6] = META_VAL[31:0];
    for (int i = 0; i < 7; i++) begin
        check_word(got_words[base + i], meta[i], "metadata word");
        check_bit(got_last[base + i], i == 6, "metadata tlast");
        check_bit(got_stamp[base + i] == got_stamp[base] + i, 1'b1, "metadata back to back");
    end
    waited = 0;
    while (o_currently_decoding && waited < 10) begin
        @(posedge clk);
        waited++;
    end
    check_bit(o_currently_decoding, 1'b0, "decoding after metadata");
    check_word(word_t'(got_words.size()), word_t'(base + 7), "total decoded words");
endtask

`endif

/* tb/tb_mrr_loopback.sv */
`timescale 1ns/100ps
`include "mrr_defines.svh"

module tb_mrr_loopback;
    import mrr_pkg::*;

    localparam int N_PAYLOAD = 24;
    localparam int RECHARGE  = 6;
    localparam int WAIT_STEP = 3;
    localparam int FFT_LEN   = 8;
    localparam int MAX_BITS  = 5 + N_PAYLOAD;
    // clocks per sample strobe, so that one bit outlasts the PN search
    localparam int STROBE_CLKS = 8;
    localparam int PACKET_STROBES = MAX_BITS * (RECHARGE + 3) * `MRR_OSR
        + WAIT_STEP * `MRR_OSR
        + `MRR_TX_WORD_BITS * `MRR_TX_CYCLES_PER_BIT * `MRR_OSR + 4 * FFT_LEN;
    localparam int TOTAL_STROBES = 16 + 2 * PACKET_STROBES;
    // each strobe takes STROBE_CLKS clocks of 10 ns, doubled for slack
    localparam int WATCHDOG_NS = TOTAL_STROBES * STROBE_CLKS * 10 * 2 + 5000;

    logic        clk;
    logic        rst;
    logic        i_fm_flag;
    esamp_t      i_sample;
    logic        i_sample_valid;
    logic        i_tx_disable;
    mrr_cycle_t  i_wait_step;
    word_t       i_tx_word;
    logic [7:0]  i_num_payload_bits;
    logic [7:0]  i_recharge_len;
    logic [15:0] i_fft_len;
    word_t       i_cfo_idx;
    word_t       i_sfo_idx;
    logic [63:0] i_cur_time;
    word_t       i_cur_corr;
    logic [63:0] i_cur_metadata;
    word_t       o_decoded_tdata;
    logic        o_decoded_tvalid;
    logic        o_decoded_tlast;
    logic        o_tkeep;
    logic        o_tx_en;
    logic        o_detector_reset;
    logic        o_currently_decoding;

    integer seed = 51;
    int     errors = 0;
    int     clk_count = 0;
    word_t  got_words [$];
    logic   got_last [$];
    int     got_stamp [$];

    mrr_loopback i_dut (
        .clk                  (clk),
        .rst                  (rst),
        .i_fm_flag            (i_fm_flag),
        .i_sample             (i_sample),
        .i_sample_valid       (i_sample_valid),
        .i_tx_disable         (i_tx_disable),
        .i_wait_step          (i_wait_step),
        .i_tx_word            (i_tx_word),
        .i_num_payload_bits   (i_num_payload_bits),
        .i_recharge_len       (i_recharge_len),
        .i_fft_len            (i_fft_len),
        .i_cfo_idx            (i_cfo_idx),
        .i_sfo_idx            (i_sfo_idx),
        .i_cur_time           (i_cur_time),
        .i_cur_corr           (i_cur_corr),
        .i_cur_metadata       (i_cur_metadata),
        .o_decoded_tdata      (o_decoded_tdata),
        .o_decoded_tvalid     (o_decoded_tvalid),
        .o_decoded_tlast      (o_decoded_tlast),
        .o_tkeep              (o_tkeep),
        .o_tx_en              (o_tx_en),
        .o_detector_reset     (o_detector_reset),
        .o_currently_decoding (o_currently_decoding)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // collect every word of the decoded stream with its clock stamp
    always @(posedge clk) begin
        clk_count <= clk_count + 1;
        if (o_decoded_tvalid) begin
            got_words.push_back(o_decoded_tdata);
            got_last.push_back(o_decoded_tlast);
            got_stamp.push_back(clk_count);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout, the tests did not finish in time");
    end

    task automatic stop_on_error();
        errors++;
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    `include "mrr_loopback_tests.svh"

    initial begin
        rst                <= 1'b1;
        i_fm_flag          <= 1'b0;
        i_sample           <= '0;
        i_sample_valid     <= 1'b0;
        i_tx_disable       <= 1'b0;
        i_wait_step        <= mrr_cycle_t'(WAIT_STEP);
        i_tx_word          <= TX_WORD;
        i_num_payload_bits <= 8'(N_PAYLOAD);
        i_recharge_len     <= 8'(RECHARGE);
        i_fft_len          <= 16'(FFT_LEN);
        i_cfo_idx          <= CFO_VAL;
        i_sfo_idx          <= SFO_VAL;
        i_cur_time         <= TIME_VAL;
        i_cur_corr         <= CORR_VAL;
        i_cur_metadata     <= META_VAL;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        run_packet(2, 1'b0);
        run_packet(5, 1'b1);
        if (errors == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "errors were found");
        end
    end

endmodule
